// ==== filelist.f ====
src/isa_pkg.sv
src/core_pkg.sv
src/alu_issue_slot.sv
src/fu_alu.sv
src/alu_result_queue.sv
src/cdb_writeback.sv
src/int_exec_top.sv
tb/int_exec_tb.sv

// ==== tb/int_exec_tb.sv ====
`timescale 1ns/10ps
/* Integer execution path testbench: random issue, branch recovery and
   bus grant traffic, checked in order against a reference model */
module int_exec_tb;

	localparam int RANDOM_CYCLES = 3000;
	localparam int STALL_LIMIT   = 100;	// cycles allowed for issue_ready_o to fall
	localparam int DRAIN_LIMIT   = 500;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  issue_valid_i;
	core_pkg::alu_issue_t  issue_pkt_i;
	logic                  issue_ready_o;
	logic                  rob_br_recovery_i;
	logic                  rob_br_pred_correct_i;
	core_pkg::br_mask_t    rob_br_tag_fix_i;
	logic                  cdb_grant_i;
	logic                  cdb_valid_o;
	core_pkg::alu_result_t cdb_res_o;

	integer                seed = 96;
	int                    waited;
	int                    delivered_cnt = 0;
	int                    squashed_cnt = 0;
	core_pkg::alu_result_t exp_q [$];	// accepted instructions in issue order

	int_exec_top #(
		.QUEUE_DEPTH (4)
	) i_dut (
		.clk                   (clk),
		.rst                   (rst),
		.issue_valid_i         (issue_valid_i),
		.issue_pkt_i           (issue_pkt_i),
		.issue_ready_o         (issue_ready_o),
		.rob_br_recovery_i     (rob_br_recovery_i),
		.rob_br_pred_correct_i (rob_br_pred_correct_i),
		.rob_br_tag_fix_i      (rob_br_tag_fix_i),
		.cdb_grant_i           (cdb_grant_i),
		.cdb_valid_o           (cdb_valid_o),
		.cdb_res_o             (cdb_res_o)
	);

	always #4 clk = ~clk;

	task automatic end_in_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			end_in_failure();
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [63:0] expect_result(input core_pkg::alu_issue_t pkt);
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] r;
		logic [5:0]  sh;
		logic [6:0]  code;
		a    = pkt.opa;
		b    = pkt.inst[isa_pkg::LIT_BIT] ? {56'd0, pkt.inst[isa_pkg::LIT_MSB:isa_pkg::LIT_LSB]}
			: pkt.opb;
		sh   = b[5:0];
		code = pkt.inst[isa_pkg::FUNC_MSB:isa_pkg::FUNC_LSB];
		case (code)
			isa_pkg::ALU_CMPULT: r = (a < b) ? 64'd1 : 64'd0;
			isa_pkg::ALU_ADDQ:   r = a + b;
			isa_pkg::ALU_SUBQ:   r = a - b;
			isa_pkg::ALU_CMPEQ:  r = (a == b) ? 64'd1 : 64'd0;
			isa_pkg::ALU_CMPULE: r = (a <= b) ? 64'd1 : 64'd0;
			isa_pkg::ALU_CMPLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			isa_pkg::ALU_CMPLE:  r = ($signed(a) <= $signed(b)) ? 64'd1 : 64'd0;
			isa_pkg::ALU_AND:    r = a & b;
			isa_pkg::ALU_BIC:    r = a & ~b;
			isa_pkg::ALU_BIS:    r = a | b;
			isa_pkg::ALU_ORNOT:  r = a | ~b;
			isa_pkg::ALU_XOR:    r = a ^ b;
			isa_pkg::ALU_EQV:    r = ~(a ^ b);
			isa_pkg::ALU_SRL:    r = a >> sh;
			isa_pkg::ALU_SLL:    r = a << sh;
			isa_pkg::ALU_SRA:    r = $signed(a) >>> sh;
			default:             r = 64'hdeadbeefbaadbeef;	// unknown function
		endcase
		return r;
	endfunction

	task automatic drop_squashed(input core_pkg::br_mask_t tag);
		core_pkg::alu_result_t keep [$];
		core_pkg::alu_result_t e;
		for (int i = 0; i < exp_q.size(); i++) begin
			e = exp_q[i];
			if ((e.br_mask & tag) == '0) begin
				keep.push_back(e);
			end else begin
				squashed_cnt++;
			end
		end
		exp_q = keep;
	endtask

	task automatic clear_fix_bits(input core_pkg::br_mask_t tag);
		core_pkg::alu_result_t e;
		for (int i = 0; i < exp_q.size(); i++) begin
			e         = exp_q[i];
			e.br_mask = e.br_mask & ~tag;
			exp_q[i]  = e;
		end
	endtask

	task automatic check_delivery();
		core_pkg::alu_result_t e;
		if (exp_q.size() == 0) begin
			$display("a result was delivered on the bus with no instruction outstanding");
			end_in_failure();
		end
		e = exp_q.pop_front();
		check_value("cdb_res_o.result", cdb_res_o.result, e.result);
		check_value("cdb_res_o.dest_tag", {58'd0, cdb_res_o.dest_tag}, {58'd0, e.dest_tag});
		check_value("cdb_res_o.rob_idx", {59'd0, cdb_res_o.rob_idx}, {59'd0, e.rob_idx});
		check_value("cdb_res_o.br_mask", {60'd0, cdb_res_o.br_mask}, {60'd0, e.br_mask});
		delivered_cnt++;
	endtask

	// delivery is checked before this edge's recovery touches the model
	always @(posedge clk) begin
		core_pkg::alu_result_t e;
		if (!rst) begin
			if (cdb_valid_o && cdb_grant_i && !rob_br_recovery_i) begin
				check_delivery();
			end
			if (issue_valid_i && issue_ready_o) begin
				e.result   = expect_result(issue_pkt_i);
				e.dest_tag = issue_pkt_i.dest_tag;
				e.rob_idx  = issue_pkt_i.rob_idx;
				e.br_mask  = issue_pkt_i.br_mask;
				exp_q.push_back(e);
			end
			if (rob_br_recovery_i) begin
				drop_squashed(rob_br_tag_fix_i);
			end else if (rob_br_pred_correct_i) begin
				clear_fix_bits(rob_br_tag_fix_i);	// also covers the one accepted now
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [6:0] pick_func(input logic [3:0] n);
		case (n)
			4'd0:    return isa_pkg::ALU_CMPULT;
			4'd1:    return isa_pkg::ALU_ADDQ;
			4'd2:    return isa_pkg::ALU_SUBQ;
			4'd3:    return isa_pkg::ALU_CMPEQ;
			4'd4:    return isa_pkg::ALU_CMPULE;
			4'd5:    return isa_pkg::ALU_CMPLT;
			4'd6:    return isa_pkg::ALU_CMPLE;
			4'd7:    return isa_pkg::ALU_AND;
			4'd8:    return isa_pkg::ALU_BIC;
			4'd9:    return isa_pkg::ALU_BIS;
			4'd10:   return isa_pkg::ALU_ORNOT;
			4'd11:   return isa_pkg::ALU_XOR;
			4'd12:   return isa_pkg::ALU_EQV;
			4'd13:   return isa_pkg::ALU_SRL;
			4'd14:   return isa_pkg::ALU_SLL;
			default: return isa_pkg::ALU_SRA;
		endcase
	endfunction

	task automatic make_packet(output core_pkg::alu_issue_t pkt);
		logic [31:0] rnd;
		rnd          = $random(seed);
		pkt.opa      = {$random(seed), $random(seed)};
		pkt.opb      = {$random(seed), $random(seed)};
		if (rnd[18:16] == 3'd0) begin
			pkt.opb = pkt.opa;	// equal operands for the compares
		end
		pkt.inst     = $random(seed);
		pkt.inst[isa_pkg::FUNC_MSB:isa_pkg::FUNC_LSB] =
			(rnd[22:19] == 4'd0) ? {2'b10, rnd[31:27]} : pick_func(rnd[26:23]);
		pkt.inst[isa_pkg::LIT_BIT] = rnd[15];
		pkt.dest_tag = rnd[5:0];
		pkt.rob_idx  = rnd[10:6];
		pkt.br_mask  = rnd[14:11];
	endtask

	// valid_mode 0 is idle, 1 random, 2 always valid
	task automatic drive_inputs(input bit events_on, input bit grant_on, input int valid_mode);
		logic [31:0]          rnd;
		core_pkg::alu_issue_t pkt;
		make_packet(pkt);
		rnd                   = $random(seed);
		issue_pkt_i           = pkt;
		issue_valid_i         = (valid_mode == 2) || (valid_mode == 1 && rnd[1:0] != 2'd0);
		cdb_grant_i           = grant_on && (rnd[3:2] != 2'd0);
		rob_br_recovery_i     = events_on && (rnd[8:4] == 5'd0);
		rob_br_pred_correct_i = events_on && (rnd[8:4] == 5'd1);
		rob_br_tag_fix_i      = 4'b0001 << rnd[10:9];	// one branch resolves at a time
	endtask

	initial begin
		rst                   = 1'b1;
		issue_valid_i         = 1'b0;
		issue_pkt_i           = '0;
		rob_br_recovery_i     = 1'b0;
		rob_br_pred_correct_i = 1'b0;
		rob_br_tag_fix_i      = '0;
		cdb_grant_i           = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_value("cdb_valid_o", {63'd0, cdb_valid_o}, 64'd0);
		check_value("issue_ready_o", {63'd0, issue_ready_o}, 64'd1);

		repeat (RANDOM_CYCLES) begin
			@(negedge clk);
			drive_inputs(1'b1, 1'b1, 1);
		end

		// with the bus stalled the queue fills up and the slot must stop accepting
		waited = 0;
		drive_inputs(1'b0, 1'b0, 2);
		@(negedge clk);
		while (issue_ready_o && waited < STALL_LIMIT) begin
			drive_inputs(1'b0, 1'b0, 2);
			@(negedge clk);
			waited++;
		end
		if (issue_ready_o) begin
			$display("issue_ready_o never fell while the bus grant was held low");
			end_in_failure();
		end
		repeat (30) begin
			drive_inputs(1'b0, 1'b0, 2);
			@(negedge clk);
		end

		repeat (RANDOM_CYCLES / 2) begin
			drive_inputs(1'b1, 1'b1, 1);
			@(negedge clk);
		end

		waited = 0;
		drive_inputs(1'b0, 1'b1, 0);
		@(negedge clk);
		while ((exp_q.size() != 0 || cdb_valid_o) && waited < DRAIN_LIMIT) begin
			drive_inputs(1'b0, 1'b1, 0);
			@(negedge clk);
			waited++;
		end
		if (waited >= DRAIN_LIMIT) begin
			$display("the pipeline did not drain, %0d accepted instructions never produced a result",
				exp_q.size());
			end_in_failure();
		end

		// any stray result that still comes out now has no instruction to match
		repeat (10) begin
			drive_inputs(1'b0, 1'b1, 0);
			@(negedge clk);
		end

		$display("%0d results delivered, %0d squashed", delivered_cnt, squashed_cnt);
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== src/int_exec_top.sv ====
`timescale 1ns/10ps
/* Integer execution path: issue slot, ALU, result queue and CDB
   writeback chained with shared branch recovery */
module int_exec_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  issue_valid_i,
	input  core_pkg::alu_issue_t  issue_pkt_i,
	output logic                  issue_ready_o,

	input  logic                  rob_br_recovery_i,
	input  logic                  rob_br_pred_correct_i,
	input  core_pkg::br_mask_t    rob_br_tag_fix_i,

	input  logic                  cdb_grant_i,
	output logic                  cdb_valid_o,
	output core_pkg::alu_result_t cdb_res_o
);

	logic                  alu_start;
	core_pkg::alu_issue_t  alu_pkt;
	logic                  alu_done;
	core_pkg::alu_result_t alu_res;
	logic                  queue_room;
	logic                  head_valid;
	core_pkg::alu_result_t head_res;
	logic                  head_pop;

	alu_issue_slot i_slot (
		.clk                   (clk),
		.rst                   (rst),
		.issue_valid_i         (issue_valid_i),
		.issue_pkt_i           (issue_pkt_i),
		.issue_ready_o         (issue_ready_o),
		.rob_br_recovery_i     (rob_br_recovery_i),
		.rob_br_pred_correct_i (rob_br_pred_correct_i),
		.rob_br_tag_fix_i      (rob_br_tag_fix_i),
		.queue_room_i          (queue_room),
		.start_o               (alu_start),
		.pkt_o                 (alu_pkt)
	);

	fu_alu i_alu (
		.clk                   (clk),
		.rst                   (rst),
		.start_i               (alu_start),
		.pkt_i                 (alu_pkt),
		.rob_br_recovery_i     (rob_br_recovery_i),
		.rob_br_pred_correct_i (rob_br_pred_correct_i),
		.rob_br_tag_fix_i      (rob_br_tag_fix_i),
		.done_o                (alu_done),
		.res_o                 (alu_res)
	);

	alu_result_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) i_queue (
		.clk                   (clk),
		.rst                   (rst),
		.wr_i                  (alu_done),
		.wr_res_i              (alu_res),
		.rob_br_recovery_i     (rob_br_recovery_i),
		.rob_br_pred_correct_i (rob_br_pred_correct_i),
		.rob_br_tag_fix_i      (rob_br_tag_fix_i),
		.room_o                (queue_room),
		.head_valid_o          (head_valid),
		.head_res_o            (head_res),
		.pop_i                 (head_pop)
	);

	cdb_writeback i_wb (
		.clk                   (clk),
		.rst                   (rst),
		.head_valid_i          (head_valid),
		.head_res_i            (head_res),
		.pop_o                 (head_pop),
		.rob_br_recovery_i     (rob_br_recovery_i),
		.rob_br_pred_correct_i (rob_br_pred_correct_i),
		.rob_br_tag_fix_i      (rob_br_tag_fix_i),
		.cdb_grant_i           (cdb_grant_i),
		.cdb_valid_o           (cdb_valid_o),
		.cdb_res_o             (cdb_res_o)
	);

endmodule

// ==== src/cdb_writeback.sv ====
`timescale 1ns/10ps
/* CDB writeback: holds the oldest finished result on the common data
   bus until granted, refilling from the result queue head */
module cdb_writeback (
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  head_valid_i,
	input  core_pkg::alu_result_t head_res_i,
	output logic                  pop_o,

	input  logic                  rob_br_recovery_i,
	input  logic                  rob_br_pred_correct_i,
	input  core_pkg::br_mask_t    rob_br_tag_fix_i,

	input  logic                  cdb_grant_i,
	output logic                  cdb_valid_o,
	output core_pkg::alu_result_t cdb_res_o
);

	logic squash;
	logic fix_en;

	assign fix_en = rob_br_pred_correct_i & ~rob_br_recovery_i;
	assign squash = rob_br_recovery_i & cdb_valid_o
		& core_pkg::br_hit(cdb_res_o.br_mask, rob_br_tag_fix_i);

	// grant is ignored during recovery, so the register only frees up outside it
	assign pop_o = head_valid_i & ~rob_br_recovery_i & (~cdb_valid_o | cdb_grant_i);

	always_ff @(posedge clk) begin
		if (rst) begin
			cdb_valid_o <= 1'b0;
		end else if (squash) begin
			cdb_valid_o <= 1'b0;
		end else if (!rob_br_recovery_i) begin
			if (pop_o) begin
				cdb_valid_o <= 1'b1;
			end else if (cdb_grant_i) begin
				cdb_valid_o <= 1'b0;	// delivered and nothing behind it
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop_o) begin
			cdb_res_o <= head_res_i;
			if (fix_en) begin
				cdb_res_o.br_mask <= core_pkg::br_clear(head_res_i.br_mask, rob_br_tag_fix_i);
			end
		end else if (fix_en) begin
			cdb_res_o.br_mask <= core_pkg::br_clear(cdb_res_o.br_mask, rob_br_tag_fix_i);
		end
	end

	a_bus_stable: assert property (@(posedge clk) disable iff (rst)
		cdb_valid_o && !cdb_grant_i && !rob_br_recovery_i && !rob_br_pred_correct_i
		|=> cdb_valid_o && $stable(cdb_res_o))
		else $error("cdb result changed while waiting for the grant");

endmodule

// ==== src/alu_result_queue.sv ====
`timescale 1ns/10ps
/* ALU result queue: circular buffer of finished results that applies
   branch squash and mask clearing to every stored entry */
module alu_result_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  wr_i,
	input  core_pkg::alu_result_t wr_res_i,

	input  logic                  rob_br_recovery_i,
	input  logic                  rob_br_pred_correct_i,
	input  core_pkg::br_mask_t    rob_br_tag_fix_i,

	output logic                  room_o,

	output logic                  head_valid_o,
	output core_pkg::alu_result_t head_res_o,
	input  logic                  pop_i
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(QUEUE_DEPTH);
	localparam logic [CNT_W-1:0] CNT_ROOM = CNT_W'(QUEUE_DEPTH - 2);	// two free slots left

	core_pkg::alu_result_t  mem [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] vld;
	logic [QUEUE_DEPTH-1:0] hit;
	logic [PTR_W-1:0]       head;
	logic [PTR_W-1:0]       tail;
	logic [CNT_W-1:0]       count;	// includes squashed entries not yet skipped
	logic                   wr_en;
	logic                   head_adv;
	logic                   fix_en;
	core_pkg::alu_result_t  wr_entry;

	assign wr_en  = wr_i & ~rob_br_recovery_i;
	assign fix_en = rob_br_pred_correct_i & ~rob_br_recovery_i;

	// a squashed head is dropped on its own, a live one waits for the pop
	assign head_adv     = (count != '0) & (pop_i | ~vld[head]);
	assign head_valid_o = (count != '0) & vld[head];
	assign head_res_o   = mem[head];
	assign room_o       = (count <= CNT_ROOM);

	always_comb begin
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			hit[i] = core_pkg::br_hit(mem[i].br_mask, rob_br_tag_fix_i);
		end
	end

	always_comb begin
		wr_entry = wr_res_i;
		if (fix_en) begin
			wr_entry.br_mask = core_pkg::br_clear(wr_res_i.br_mask, rob_br_tag_fix_i);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pointers and occupancy
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				tail <= tail + PTR_W'(1);	// wraps, depth is a power of two
			end
			if (head_adv) begin
				head <= head + PTR_W'(1);
			end
			count <= count + CNT_W'(wr_en) - CNT_W'(head_adv);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld <= '0;
		end else begin
			if (rob_br_recovery_i) begin
				vld <= vld & ~hit;
			end
			if (head_adv) begin
				vld[head] <= 1'b0;
			end
			if (wr_en) begin
				vld[tail] <= 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (fix_en) begin
			for (int i = 0; i < QUEUE_DEPTH; i++) begin
				mem[i].br_mask <= core_pkg::br_clear(mem[i].br_mask, rob_br_tag_fix_i);
			end
		end
		if (wr_en) begin
			mem[tail] <= wr_entry;
		end
	end

	// the slot only launches with two free entries, so the ALU can never overrun us
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> count != CNT_FULL)
		else $error("result written into a full queue");

	a_pop_valid: assert property (@(posedge clk) disable iff (rst)
		pop_i |-> head_valid_o)
		else $error("queue popped without a valid head");

endmodule

// ==== src/fu_alu.sv ====
`timescale 1ns/10ps
/* Integer ALU: computes one operate instruction per cycle into a
   registered result, tracking and squashing its branch mask */
module fu_alu (
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  start_i,
	input  core_pkg::alu_issue_t  pkt_i,

	input  logic                  rob_br_recovery_i,
	input  logic                  rob_br_pred_correct_i,
	input  core_pkg::br_mask_t    rob_br_tag_fix_i,

	output logic                  done_o,
	output core_pkg::alu_result_t res_o
);

	core_pkg::word_t       opa;
	core_pkg::word_t       opb;
	core_pkg::word_t       lit;
	logic [5:0]            shamt;
	isa_pkg::alu_func_e    func;
	core_pkg::word_t       result_nxt;
	core_pkg::alu_result_t res_nxt;
	logic                  squash;

	// two's complement less-than built from the unsigned compare
	function automatic logic signed_lt(input core_pkg::word_t a, input core_pkg::word_t b);
		logic lt;
		if (a[core_pkg::WORD_W-1] != b[core_pkg::WORD_W-1]) begin
			lt = a[core_pkg::WORD_W-1];	// the negative one is smaller
		end else begin
			lt = (a < b);
		end
		return lt;
	endfunction

	assign lit   = core_pkg::word_t'(pkt_i.inst[isa_pkg::LIT_MSB:isa_pkg::LIT_LSB]);
	assign opa   = pkt_i.opa;
	assign opb   = pkt_i.inst[isa_pkg::LIT_BIT] ? lit : pkt_i.opb;
	assign shamt = opb[5:0];
	assign func  = isa_pkg::alu_func_e'(pkt_i.inst[isa_pkg::FUNC_MSB:isa_pkg::FUNC_LSB]);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// function decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (func)
			isa_pkg::ALU_CMPULT: result_nxt = core_pkg::word_t'(opa < opb);
			isa_pkg::ALU_ADDQ:   result_nxt = opa + opb;
			isa_pkg::ALU_SUBQ:   result_nxt = opa - opb;
			isa_pkg::ALU_CMPEQ:  result_nxt = core_pkg::word_t'(opa == opb);
			isa_pkg::ALU_CMPULE: result_nxt = core_pkg::word_t'(opa <= opb);
			isa_pkg::ALU_CMPLT:  result_nxt = core_pkg::word_t'(signed_lt(opa, opb));
			isa_pkg::ALU_CMPLE:  result_nxt = core_pkg::word_t'(signed_lt(opa, opb) | (opa == opb));
			isa_pkg::ALU_AND:    result_nxt = opa & opb;
			isa_pkg::ALU_BIC:    result_nxt = opa & ~opb;
			isa_pkg::ALU_BIS:    result_nxt = opa | opb;
			isa_pkg::ALU_ORNOT:  result_nxt = opa | ~opb;
			isa_pkg::ALU_XOR:    result_nxt = opa ^ opb;
			isa_pkg::ALU_EQV:    result_nxt = opa ^ ~opb;
			isa_pkg::ALU_SRL:    result_nxt = opa >> shamt;
			isa_pkg::ALU_SLL:    result_nxt = opa << shamt;
			isa_pkg::ALU_SRA:    result_nxt = core_pkg::word_t'($signed(opa) >>> shamt);
			default:             result_nxt = isa_pkg::ALU_BAD_RESULT;
		endcase
	end

	always_comb begin
		res_nxt.result   = result_nxt;
		res_nxt.dest_tag = pkt_i.dest_tag;
		res_nxt.rob_idx  = pkt_i.rob_idx;
		res_nxt.br_mask  = rob_br_pred_correct_i
			? core_pkg::br_clear(pkt_i.br_mask, rob_br_tag_fix_i) : pkt_i.br_mask;
	end

	assign squash = rob_br_recovery_i & done_o
		& core_pkg::br_hit(res_o.br_mask, rob_br_tag_fix_i);

	always_ff @(posedge clk) begin
		if (rst) begin
			done_o <= 1'b0;
		end else if (squash) begin
			done_o <= 1'b0;
		end else if (!rob_br_recovery_i) begin
			done_o <= start_i;	// a surviving result just waits out the recovery
		end
	end

	always_ff @(posedge clk) begin
		if (!rob_br_recovery_i) begin
			res_o <= res_nxt;
		end
	end

	// the result register ignores a start during recovery, so it would be lost
	a_no_start_in_recovery: assert property (@(posedge clk) disable iff (rst)
		rob_br_recovery_i |-> !start_i)
		else $error("alu started during branch recovery and the instruction is lost");

endmodule

// ==== src/alu_issue_slot.sv ====
`timescale 1ns/10ps
/* ALU issue slot: holds one renamed instruction and launches it into
   the ALU once the result queue reports room for it */
module alu_issue_slot (
	input  logic                 clk,
	input  logic                 rst,

	input  logic                 issue_valid_i,
	input  core_pkg::alu_issue_t issue_pkt_i,
	output logic                 issue_ready_o,

	input  logic                 rob_br_recovery_i,
	input  logic                 rob_br_pred_correct_i,
	input  core_pkg::br_mask_t   rob_br_tag_fix_i,

	input  logic                 queue_room_i,
	output logic                 start_o,
	output core_pkg::alu_issue_t pkt_o
);

	logic                 slot_valid;
	core_pkg::alu_issue_t slot_pkt;
	logic                 accept;
	logic                 squash;
	logic                 fix_en;

	assign fix_en  = rob_br_pred_correct_i & ~rob_br_recovery_i;
	assign squash  = rob_br_recovery_i & slot_valid
		& core_pkg::br_hit(slot_pkt.br_mask, rob_br_tag_fix_i);

	// nothing moves during a recovery cycle
	assign start_o       = slot_valid & queue_room_i & ~rob_br_recovery_i;
	assign issue_ready_o = ~rob_br_recovery_i & (~slot_valid | start_o);	// refill while launching
	assign accept        = issue_valid_i & issue_ready_o;
	assign pkt_o         = slot_pkt;

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_valid <= 1'b0;
		end else if (squash) begin
			slot_valid <= 1'b0;
		end else if (accept) begin
			slot_valid <= 1'b1;
		end else if (start_o) begin
			slot_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			slot_pkt <= issue_pkt_i;
			if (fix_en) begin
				slot_pkt.br_mask <= core_pkg::br_clear(issue_pkt_i.br_mask, rob_br_tag_fix_i);
			end
		end else if (fix_en) begin
			slot_pkt.br_mask <= core_pkg::br_clear(slot_pkt.br_mask, rob_br_tag_fix_i);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_squash_empties_slot: assert property (@(posedge clk) disable iff (rst)
		rob_br_recovery_i
		|=> !(slot_valid && core_pkg::br_hit(slot_pkt.br_mask, $past(rob_br_tag_fix_i))))
		else $error("issue slot kept an instruction that branch recovery squashed");

endmodule

// ==== src/core_pkg.sv ====
/* Core package: register and ROB tag widths, the packets of the
   integer execution path and the branch-mask helpers of every stage */
package core_pkg;

	localparam int WORD_W    = 64;
	localparam int PRF_IDX_W = 6;	// 64 physical registers
	localparam int ROB_IDX_W = 5;	// 32 ROB entries
	localparam int BR_MASK_W = 4;	// up to four unresolved branches

	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [PRF_IDX_W-1:0] prf_idx_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [BR_MASK_W-1:0] br_mask_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// packets
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		word_t          opa;
		word_t          opb;
		isa_pkg::inst_t inst;
		prf_idx_t       dest_tag;
		rob_idx_t       rob_idx;
		br_mask_t       br_mask;	// branches this instruction depends on
	} alu_issue_t;

	typedef struct packed {
		word_t    result;
		prf_idx_t dest_tag;
		rob_idx_t rob_idx;
		br_mask_t br_mask;
	} alu_result_t;

	// an entry dies on a mispredict when it depends on the resolved branch
	function automatic logic br_hit(input br_mask_t mask, input br_mask_t fix);
		return |(mask & fix);
	endfunction

	// a correctly predicted branch no longer guards anything
	function automatic br_mask_t br_clear(input br_mask_t mask, input br_mask_t fix);
		return mask & ~fix;
	endfunction

endpackage

// ==== src/isa_pkg.sv ====
/* ISA package: operate-format instruction fields, ALU function
   encodings and the result returned for an unknown function */
package isa_pkg;

	typedef logic [31:0] inst_t;	// one instruction word

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operate format field positions
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int FUNC_LSB = 5;
	localparam int FUNC_MSB = 11;
	localparam int LIT_BIT  = 12;	// set means operand b is the literal
	localparam int LIT_LSB  = 13;
	localparam int LIT_MSB  = 20;	// 8-bit literal, zero extended to a word

	// function codes are grouped by kind, gaps between groups are unused
	typedef enum logic [6:0] {
		ALU_CMPULT = 7'h00,
		ALU_ADDQ   = 7'h01,
		ALU_SUBQ   = 7'h02,
		ALU_CMPEQ  = 7'h03,
		ALU_CMPULE = 7'h04,
		ALU_CMPLT  = 7'h05,
		ALU_CMPLE  = 7'h06,
		ALU_AND    = 7'h10,	// logical group
		ALU_BIC    = 7'h11,
		ALU_BIS    = 7'h12,
		ALU_ORNOT  = 7'h13,
		ALU_XOR    = 7'h14,
		ALU_EQV    = 7'h15,
		ALU_SRL    = 7'h20,	// shift group
		ALU_SLL    = 7'h21,
		ALU_SRA    = 7'h22
	} alu_func_e;

	// poison value so that a bad decode is easy to spot on the bus
	localparam logic [63:0] ALU_BAD_RESULT = 64'hdead_beef_baad_beef;

endpackage
